//--- source/cpuPackage.sv
`default_nettype none

package cpuPackage;

    localparam int memoryWords = 256;
    localparam int memoryAddressBits = 8;
    localparam int ledSelectBit = 31;   // Upper half of the map is the LED port

    localparam logic [6:0] opcodeOp = 7'b0110011;
    localparam logic [6:0] opcodeOpImm = 7'b0010011;
    localparam logic [6:0] opcodeLui = 7'b0110111;
    localparam logic [6:0] opcodeLoad = 7'b0000011;
    localparam logic [6:0] opcodeStore = 7'b0100011;
    localparam logic [6:0] opcodeBranch = 7'b1100011;
    localparam logic [6:0] opcodeJal = 7'b1101111;

    localparam logic [6:0] functSub = 7'b0100000;
    localparam logic [2:0] functBeq = 3'b000;
    localparam logic [2:0] functBne = 3'b001;

    // One instruction word, viewed in each RV32I format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } iType;
        struct packed {
            logic [6:0] immHigh;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLow;
            logic [6:0] opcode;
        } sType;
        struct packed {
            logic immSign;      // imm[12]
            logic [5:0] immHigh;    // imm[10:5]
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] immLow;     // imm[4:1]
            logic immBit11;
            logic [6:0] opcode;
        } bType;
        struct packed {
            logic [19:0] imm;
            logic [4:0] rd;
            logic [6:0] opcode;
        } uType;
        struct packed {
            logic immSign;      // imm[20]
            logic [9:0] immLow;     // imm[10:1]
            logic immBit11;
            logic [7:0] immHigh;    // imm[19:12]
            logic [4:0] rd;
            logic [6:0] opcode;
        } jType;
    } instructionWord;

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluPassB
    } aluOperation;

endpackage

`default_nettype wire

//--- source/memoryBus.sv
`timescale 1ns/1ps
`default_nettype none

interface memoryBus;
    logic read;
    logic write;
    logic [31:0] address;
    logic [31:0] writeData;
    logic [31:0] readData;
    logic readDone;     // One-cycle pulse, readData valid with it
    logic writeDone;

    modport requester (
        output read, write, address, writeData,
        input  readData, readDone, writeDone
    );

    modport memory (
        input  read, write, address, writeData,
        output readData, readDone, writeDone
    );
endinterface

`default_nettype wire

//--- source/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic                    Clock,
    input  logic                    reset,
    memoryBus.requester             fetchBus,
    memoryBus.requester             dataBus,
    output logic [4:0]              readAddressA,
    output logic [4:0]              readAddressB,
    output logic [4:0]              writeAddress,
    output logic                    writeEnable,
    output logic [31:0]             writeValue,
    input  logic [31:0]             readValueA,
    input  logic [31:0]             readValueB,
    output cpuPackage::aluOperation operation,
    output logic [31:0]             operandA,
    output logic [31:0]             operandB,
    input  logic [31:0]             result,
    input  logic                    equal
);
    import cpuPackage::*;

    typedef enum logic [2:0] {fetch, decode, execute, memory, writeback} controlState;

    controlState state;
    instructionWord instruction;
    logic [31:0] programCounter;
    logic [31:0] pcPlusFour;
    logic [31:0] jumpTarget;
    logic [31:0] aluResult;     // Also the data address for loads and stores
    logic [31:0] storeValue;
    logic fetchRead;
    logic dataRead;
    logic dataWrite;
    logic [6:0] opcode;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;
    logic branchTaken;

    assign opcode = instruction.rType.opcode;
    assign readAddressA = instruction.rType.rs1;
    assign readAddressB = instruction.rType.rs2;
    assign writeAddress = instruction.rType.rd;
    assign pcPlusFour = programCounter + 32'd4;

    assign immI = {{20{instruction.iType.imm[11]}}, instruction.iType.imm};
    assign immS = {{20{instruction.sType.immHigh[6]}}, instruction.sType.immHigh,
                   instruction.sType.immLow};
    assign immB = {{19{instruction.bType.immSign}}, instruction.bType.immSign,
                   instruction.bType.immBit11, instruction.bType.immHigh,
                   instruction.bType.immLow, 1'b0};
    assign immU = {instruction.uType.imm, 12'd0};
    assign immJ = {{11{instruction.jType.immSign}}, instruction.jType.immSign,
                   instruction.jType.immHigh, instruction.jType.immBit11,
                   instruction.jType.immLow, 1'b0};

    assign branchTaken = (instruction.bType.funct3 == functBeq) ? equal :
                         (instruction.bType.funct3 == functBne) ? !equal : 1'b0;

    assign fetchBus.read = fetchRead;
    assign fetchBus.write = 1'b0;   // Program memory is read-only from the core
    assign fetchBus.address = programCounter;
    assign fetchBus.writeData = '0;
    assign dataBus.read = dataRead;
    assign dataBus.write = dataWrite;
    assign dataBus.address = aluResult;
    assign dataBus.writeData = storeValue;

    // Decode pass computes the jump target, execute pass the result
    always_comb begin
        operation = aluAdd;
        operandA = readValueA;
        operandB = readValueB;
        if (state == decode) begin
            operandA = programCounter;
            operandB = (opcode == opcodeJal) ? immJ : immB;
        end else if (state == execute) begin
            case (opcode)
                opcodeOp: if (instruction.rType.funct7 == functSub) operation = aluSub;
                opcodeOpImm, opcodeLoad: operandB = immI;
                opcodeStore: operandB = immS;
                opcodeLui: begin
                    operation = aluPassB;
                    operandB = immU;
                end
                opcodeJal: begin    // Link address
                    operandA = programCounter;
                    operandB = 32'd4;
                end
                default: operation = aluAdd;
            endcase
        end
    end

    always_comb begin
        writeEnable = 1'b0;
        writeValue = aluResult;
        case (state)
            writeback: writeEnable = 1'b1;
            execute: if (opcode == opcodeJal) begin
                writeEnable = 1'b1;
                writeValue = result;
            end
            memory: if (opcode == opcodeLoad && dataBus.readDone) begin
                writeEnable = 1'b1;
                writeValue = dataBus.readData;
            end
            default: writeEnable = 1'b0;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            state <= fetch;
            programCounter <= '0;
            fetchRead <= 1'b0;
            dataRead <= 1'b0;
            dataWrite <= 1'b0;
        end else begin
            case (state)
                fetch: begin
                    if (fetchBus.readDone) begin
                        fetchRead <= 1'b0;
                        state <= decode;
                    end else begin
                        fetchRead <= 1'b1;  // Only needed right after reset
                    end
                end
                decode: state <= execute;
                execute: begin
                    case (opcode)
                        opcodeOp, opcodeOpImm, opcodeLui: state <= writeback;
                        opcodeLoad: begin
                            dataRead <= 1'b1;
                            state <= memory;
                        end
                        opcodeStore: begin
                            dataWrite <= 1'b1;
                            state <= memory;
                        end
                        opcodeBranch: begin
                            programCounter <= branchTaken ? jumpTarget : pcPlusFour;
                            fetchRead <= 1'b1;
                            state <= fetch;
                        end
                        opcodeJal: begin
                            programCounter <= jumpTarget;
                            fetchRead <= 1'b1;
                            state <= fetch;
                        end
                        default: begin  // Unsupported opcode
                            programCounter <= pcPlusFour;
                            fetchRead <= 1'b1;
                            state <= fetch;
                        end
                    endcase
                end
                memory: begin
                    if (dataBus.readDone || dataBus.writeDone) begin
                        dataRead <= 1'b0;
                        dataWrite <= 1'b0;
                        programCounter <= pcPlusFour;
                        fetchRead <= 1'b1;
                        state <= fetch;
                    end
                end
                writeback: begin
                    programCounter <= pcPlusFour;
                    fetchRead <= 1'b1;
                    state <= fetch;
                end
                default: state <= fetch;
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (state == fetch && fetchBus.readDone) instruction <= fetchBus.readData;
        if (state == decode) jumpTarget <= result;
        if (state == execute) begin
            aluResult <= result;
            storeValue <= readValueB;
        end
    end

endmodule

`default_nettype wire

//--- source/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic        Clock,
    input  logic        reset,
    input  logic [4:0]  readAddressA,
    input  logic [4:0]  readAddressB,
    input  logic [4:0]  writeAddress,
    input  logic        writeEnable,
    input  logic [31:0] writeValue,
    output logic [31:0] readValueA,
    output logic [31:0] readValueB
);
    logic [31:0] registers [32];

    // x0 is hardwired, whatever was written to it
    assign readValueA = (readAddressA == 5'd0) ? 32'd0 : registers[readAddressA];
    assign readValueB = (readAddressB == 5'd0) ? 32'd0 : registers[readAddressB];

    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int index = 0; index < 32; index++) begin
                registers[index] <= '0;
            end
        end else if (writeEnable) begin
            registers[writeAddress] <= writeValue;
        end
    end

endmodule

`default_nettype wire

//--- source/arithmeticUnit.sv
`timescale 1ns/1ps
`default_nettype none

module arithmeticUnit (
    input  cpuPackage::aluOperation operation,
    input  logic [31:0]             operandA,
    input  logic [31:0]             operandB,
    output logic [31:0]             result,
    output logic                    equal
);
    import cpuPackage::*;

    // Shared by target, result and address computation
    always_comb begin
        case (operation)
            aluAdd: result = operandA + operandB;
            aluSub: result = operandA - operandB;
            aluPassB: result = operandB;   // LUI
            default: result = operandA + operandB;
        endcase
    end

    assign equal = (operandA == operandB);  // Branch condition

endmodule

`default_nettype wire

//--- source/programMemory.sv
`timescale 1ns/1ps
`default_nettype none

module programMemory (
    input  logic                                   Clock,
    input  logic                                   loadEnable,
    input  logic [cpuPackage::memoryAddressBits-1:0] loadAddress,
    input  logic [31:0]                            loadData,
    memoryBus.memory                               fetchBus
);
    import cpuPackage::*;

    logic [31:0] words [memoryWords];
    logic [memoryAddressBits-1:0] fetchIndex;

    assign fetchIndex = fetchBus.address[memoryAddressBits+1:2];
    assign fetchBus.writeDone = 1'b0;   // Never written over the bus

    always_ff @(posedge Clock) begin
        if (loadEnable) words[loadAddress] <= loadData;
    end

    // Done follows the request by one cycle, then the request is ignored once
    always_ff @(posedge Clock) begin
        fetchBus.readDone <= fetchBus.read && !fetchBus.readDone;
        if (fetchBus.read && !fetchBus.readDone) fetchBus.readData <= words[fetchIndex];
    end

endmodule

`default_nettype wire

//--- source/dataMemory.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemory (
    input  logic     Clock,
    input  logic     reset,
    memoryBus.memory ramBus
);
    import cpuPackage::*;

    logic [31:0] words [memoryWords];
    logic [memoryAddressBits-1:0] wordIndex;
    logic readAccepted;
    logic writeAccepted;

    assign wordIndex = ramBus.address[memoryAddressBits+1:2];
    // A request still up during its done cycle is already served
    assign readAccepted = ramBus.read && !ramBus.readDone;
    assign writeAccepted = ramBus.write && !ramBus.writeDone;

    always_ff @(posedge Clock) begin
        if (reset) begin
            ramBus.readDone <= 1'b0;
            ramBus.writeDone <= 1'b0;
        end else begin
            ramBus.readDone <= readAccepted;
            ramBus.writeDone <= writeAccepted;
        end
    end

    always_ff @(posedge Clock) begin
        if (writeAccepted) words[wordIndex] <= ramBus.writeData;
        if (readAccepted) ramBus.readData <= words[wordIndex];
    end

endmodule

`default_nettype wire

//--- source/peripheralDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module peripheralDecoder (
    input  logic        Clock,
    input  logic        reset,
    memoryBus.memory    dataBus,
    memoryBus.requester ramBus,
    output logic [7:0]  led,
    output logic        ledStrobe
);
    import cpuPackage::*;

    logic ledSelect;

    assign ledSelect = dataBus.address[ledSelectBit];

    // RAM side sees only its own accesses
    assign ramBus.read = dataBus.read && !ledSelect;
    assign ramBus.write = dataBus.write && !ledSelect;
    assign ramBus.address = dataBus.address;
    assign ramBus.writeData = dataBus.writeData;

    // LED accesses complete in the same cycle
    assign dataBus.readData = ledSelect ? 32'd0 : ramBus.readData;
    assign dataBus.readDone = ledSelect ? dataBus.read : ramBus.readDone;
    assign dataBus.writeDone = ledSelect ? dataBus.write : ramBus.writeDone;

    always_ff @(posedge Clock) begin
        if (reset) begin
            led <= '0;
            ledStrobe <= 1'b0;
        end else begin
            ledStrobe <= 1'b0;
            if (ledSelect && dataBus.write) begin
                led <= dataBus.writeData[7:0];
                ledStrobe <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/processorTop.sv
`timescale 1ns/1ps
`default_nettype none

module processorTop (
    input  logic                                        Clock,
    input  logic                                        reset,
    input  logic                                        loadEnable,
    input  logic [$clog2(cpuPackage::memoryWords)-1:0]  loadAddress,
    input  logic [31:0]                                 loadData,
    output logic [7:0]                                  led,
    output logic                                        ledStrobe
);
    import cpuPackage::*;

    logic [4:0] readAddressA;
    logic [4:0] readAddressB;
    logic [4:0] writeAddress;
    logic writeEnable;
    logic [31:0] writeValue;
    logic [31:0] readValueA;
    logic [31:0] readValueB;
    aluOperation operation;
    logic [31:0] operandA;
    logic [31:0] operandB;
    logic [31:0] result;
    logic equal;

    memoryBus fetchBus ();
    memoryBus dataBus ();
    memoryBus ramBus ();

    controlUnit core (
        .Clock(Clock),
        .reset(reset),
        .fetchBus(fetchBus.requester),
        .dataBus(dataBus.requester),
        .readAddressA(readAddressA),
        .readAddressB(readAddressB),
        .writeAddress(writeAddress),
        .writeEnable(writeEnable),
        .writeValue(writeValue),
        .readValueA(readValueA),
        .readValueB(readValueB),
        .operation(operation),
        .operandA(operandA),
        .operandB(operandB),
        .result(result),
        .equal(equal)
    );

    registerFile registers (
        .Clock(Clock),
        .reset(reset),
        .readAddressA(readAddressA),
        .readAddressB(readAddressB),
        .writeAddress(writeAddress),
        .writeEnable(writeEnable),
        .writeValue(writeValue),
        .readValueA(readValueA),
        .readValueB(readValueB)
    );

    arithmeticUnit alu (
        .operation(operation),
        .operandA(operandA),
        .operandB(operandB),
        .result(result),
        .equal(equal)
    );

    programMemory programStore (
        .Clock(Clock),
        .loadEnable(loadEnable && reset),   // Loading only while held in reset
        .loadAddress(loadAddress),
        .loadData(loadData),
        .fetchBus(fetchBus.memory)
    );

    peripheralDecoder decoder (
        .Clock(Clock),
        .reset(reset),
        .dataBus(dataBus.memory),
        .ramBus(ramBus.requester),
        .led(led),
        .ledStrobe(ledStrobe)
    );

    dataMemory dataStore (
        .Clock(Clock),
        .reset(reset),
        .ramBus(ramBus.memory)
    );

endmodule

`default_nettype wire

//--- bench/processorAssertions.sv
`timescale 1ns/1ps
`default_nettype none

module processorAssertions (
    input logic Clock,
    input logic reset,
    input logic fetchRead, fetchWrite, fetchReadDone, fetchWriteDone,
    input logic dataRead, dataWrite, dataReadDone, dataWriteDone,
    input logic ramRead, ramWrite, ramReadDone, ramWriteDone,
    input logic ledStrobe
);
    int failureCount = 0;   // Read by the testbench at the end

    exclusiveRequest: assert property (@(posedge Clock) disable iff (reset)
        !(fetchRead && fetchWrite) && !(dataRead && dataWrite) && !(ramRead && ramWrite))
        else begin
            $error("read and write high together on a bus");
            failureCount++;
        end

    // Request is held until done, so it must still be up
    fetchDoneHasRequest: assert property (@(posedge Clock) disable iff (reset)
        (!fetchReadDone || fetchRead) && (!fetchWriteDone || fetchWrite))
        else begin
            $error("done on fetch bus without a request");
            failureCount++;
        end

    dataDoneHasRequest: assert property (@(posedge Clock) disable iff (reset)
        (!dataReadDone || dataRead) && (!dataWriteDone || dataWrite))
        else begin
            $error("done on data bus without a request");
            failureCount++;
        end

    ramDoneHasRequest: assert property (@(posedge Clock) disable iff (reset)
        (!ramReadDone || ramRead) && (!ramWriteDone || ramWrite))
        else begin
            $error("done on RAM bus without a request");
            failureCount++;
        end

    strobeSingleCycle: assert property (@(posedge Clock) disable iff (reset)
        ledStrobe |=> !ledStrobe)
        else begin
            $error("LED strobe high for two cycles");
            failureCount++;
        end

endmodule

bind processorTop processorAssertions busChecks (
    .Clock(Clock),
    .reset(reset),
    .fetchRead(fetchBus.read),
    .fetchWrite(fetchBus.write),
    .fetchReadDone(fetchBus.readDone),
    .fetchWriteDone(fetchBus.writeDone),
    .dataRead(dataBus.read),
    .dataWrite(dataBus.write),
    .dataReadDone(dataBus.readDone),
    .dataWriteDone(dataBus.writeDone),
    .ramRead(ramBus.read),
    .ramWrite(ramBus.write),
    .ramReadDone(ramBus.readDone),
    .ramWriteDone(ramBus.writeDone),
    .ledStrobe(ledStrobe)
);

`default_nettype wire

//--- bench/processorChecker.sv
`timescale 1ns/1ps
`default_nettype none

module processorChecker (
    input logic       Clock,
    input logic [7:0] led,
    input logic       ledStrobe
);
    int errorCount = 0;
    int passedTests = 0;
    int failedTests = 0;

    // Called right after reset is released
    task automatic checkTest(input string testName, input int expectedCount,
                             input logic [7:0][7:0] expectedValues);
        int testErrors;
        int waited;
        testErrors = 0;
        @(negedge Clock);
        if (led !== 8'd0) begin
            $display("error: %s expected %h actual %h (led after reset)", testName, 8'd0, led);
            testErrors++;
        end
        for (int index = 0; index < expectedCount; index++) begin
            waited = 0;
            do begin
                @(negedge Clock);   // Outputs settled mid-cycle
                waited++;
            end while (ledStrobe !== 1'b1 && waited < 200);
            if (ledStrobe !== 1'b1) begin
                $display("%s: LED write number %0d never came within 200 cycles",
                         testName, index + 1);
                testErrors++;
                break;
            end else if (led !== expectedValues[index]) begin
                $display("error: %s expected %h actual %h", testName, expectedValues[index], led);
                testErrors++;
            end
        end
        errorCount += testErrors;
        if (testErrors == 0) begin
            passedTests++;
            $display("test %s passed", testName);
        end else begin
            failedTests++;
            $display("test %s failed with %0d errors", testName, testErrors);
        end
    endtask

endmodule

`default_nettype wire

//--- bench/processorBench.sv
`timescale 1ns/1ps
`default_nettype none

module processorBench;
    import cpuPackage::*;

    logic Clock = 1'b0;
    logic reset = 1'b1;
    logic loadEnable = 1'b0;
    logic [memoryAddressBits-1:0] loadAddress = '0;
    logic [31:0] loadData = '0;
    logic [7:0] led;
    logic ledStrobe;
    logic [31:0] randomState = 32'h52dacf5a;

    string testNames [5];
    logic [31:0] programWords [5][12];
    int expectedCounts [5];
    logic [7:0][7:0] expectedLeds [5];

    processorTop uut (
        .Clock(Clock),
        .reset(reset),
        .loadEnable(loadEnable),
        .loadAddress(loadAddress),
        .loadData(loadData),
        .led(led),
        .ledStrobe(ledStrobe)
    );

    processorChecker ledChecker (
        .Clock(Clock),
        .led(led),
        .ledStrobe(ledStrobe)
    );

    always #20 Clock = ~Clock;

    function automatic logic [31:0] encodeR(logic [6:0] funct7, int rd, int rs1, int rs2);
        instructionWord word;
        word.rType = '{funct7, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], opcodeOp};
        return word;
    endfunction

    function automatic logic [31:0] encodeI(logic [6:0] opcode, logic [2:0] funct3,
                                            int rd, int rs1, int imm);
        instructionWord word;
        word.iType = '{imm[11:0], rs1[4:0], funct3, rd[4:0], opcode};
        return word;
    endfunction

    function automatic logic [31:0] encodeS(int rs2, int rs1, int imm);
        instructionWord word;
        word.sType = '{imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opcodeStore};
        return word;
    endfunction

    function automatic logic [31:0] encodeB(logic [2:0] funct3, int rs1, int rs2, int offset);
        instructionWord word;
        word.bType = '{offset[12], offset[10:5], rs2[4:0], rs1[4:0], funct3,
                       offset[4:1], offset[11], opcodeBranch};
        return word;
    endfunction

    function automatic logic [31:0] encodeU(int rd, int upper);
        instructionWord word;
        word.uType = '{upper[19:0], rd[4:0], opcodeLui};
        return word;
    endfunction

    function automatic logic [31:0] encodeJ(int rd, int offset);
        instructionWord word;
        word.jType = '{offset[20], offset[10:1], offset[11], offset[19:12], rd[4:0], opcodeJal};
        return word;
    endfunction

    // LCG step, then a signed 12-bit immediate from the upper bits
    function automatic int randomImmediate();
        randomState = randomState * 32'd1664525 + 32'd1013904223;
        return {{20{randomState[27]}}, randomState[27:16]};
    endfunction

    task automatic buildPrograms();
        int immA;
        int immB;
        int ledUpper;
        immA = randomImmediate();
        immB = randomImmediate();
        ledUpper = 1 << (ledSelectBit - 12);
        for (int test = 0; test < 5; test++) begin
            for (int index = 0; index < 12; index++) programWords[test][index] = '0;
            programWords[test][0] = encodeU(5, ledUpper);    // x5 points at the LED
        end
        testNames[0] = "arithmetic";
        programWords[0][1] = encodeI(opcodeOpImm, 3'b000, 1, 0, 100);
        programWords[0][2] = encodeI(opcodeOpImm, 3'b000, 2, 0, 37);
        programWords[0][3] = encodeR(7'd0, 3, 1, 2);
        programWords[0][4] = encodeS(3, 5, 0);
        programWords[0][5] = encodeR(functSub, 4, 1, 2);
        programWords[0][6] = encodeS(4, 5, 0);
        programWords[0][7] = encodeR(functSub, 6, 2, 1);
        programWords[0][8] = encodeS(6, 5, 0);
        programWords[0][9] = encodeJ(0, 0);
        expectedCounts[0] = 3;
        expectedLeds[0] = '0;
        expectedLeds[0][0] = 8'(100 + 37);
        expectedLeds[0][1] = 8'(100 - 37);
        expectedLeds[0][2] = 8'(37 - 100);
        testNames[1] = "random immediates";
        programWords[1][1] = encodeI(opcodeOpImm, 3'b000, 1, 0, immA);
        programWords[1][2] = encodeS(1, 5, 0);
        programWords[1][3] = encodeI(opcodeOpImm, 3'b000, 2, 0, immB);
        programWords[1][4] = encodeR(7'd0, 1, 1, 2);
        programWords[1][5] = encodeS(1, 5, 0);
        programWords[1][6] = encodeR(7'd0, 1, 1, 2);
        programWords[1][7] = encodeS(1, 5, 0);
        programWords[1][8] = encodeJ(0, 0);
        expectedCounts[1] = 3;
        expectedLeds[1] = '0;
        expectedLeds[1][0] = 8'(immA);
        expectedLeds[1][1] = 8'(immA + immB);
        expectedLeds[1][2] = 8'(immA + 2 * immB);
        testNames[2] = "memory round trip";
        programWords[2][1] = encodeI(opcodeOpImm, 3'b000, 1, 0, 'h5a);
        programWords[2][2] = encodeS(1, 0, 64);
        programWords[2][3] = encodeI(opcodeOpImm, 3'b000, 1, 0, 7);    // Clobber x1
        programWords[2][4] = encodeI(opcodeLoad, 3'b010, 2, 0, 64);
        programWords[2][5] = encodeS(2, 5, 0);
        programWords[2][6] = encodeS(1, 5, 0);
        programWords[2][7] = encodeJ(0, 0);
        expectedCounts[2] = 2;
        expectedLeds[2] = '0;
        expectedLeds[2][0] = 8'h5a;
        expectedLeds[2][1] = 8'd7;
        testNames[3] = "branches and jumps";
        programWords[3][1] = encodeI(opcodeOpImm, 3'b000, 1, 0, 3);
        programWords[3][2] = encodeS(1, 5, 0);               // Loop head
        programWords[3][3] = encodeI(opcodeOpImm, 3'b000, 1, 1, -1);
        programWords[3][4] = encodeB(functBne, 1, 0, -8);
        programWords[3][5] = encodeB(functBeq, 1, 5, 8);     // Not taken
        programWords[3][6] = encodeB(functBeq, 1, 0, 8);     // Taken, skips the store
        programWords[3][7] = encodeS(5, 5, 0);
        programWords[3][8] = encodeJ(3, 8);
        programWords[3][9] = encodeJ(0, 0);
        programWords[3][10] = encodeS(3, 5, 0);
        programWords[3][11] = encodeJ(0, 0);
        expectedCounts[3] = 4;
        expectedLeds[3] = '0;
        expectedLeds[3][0] = 8'd3;
        expectedLeds[3][1] = 8'd2;
        expectedLeds[3][2] = 8'd1;
        expectedLeds[3][3] = 8'(8 * 4 + 4);    // Link of the JAL at word 8
        testNames[4] = "reset and register zero";
        programWords[4][1] = encodeS(3, 5, 0);     // x3 was set by the previous test
        programWords[4][2] = encodeI(opcodeOpImm, 3'b000, 0, 0, 55);
        programWords[4][3] = encodeS(0, 5, 0);
        programWords[4][4] = encodeI(opcodeOpImm, 3'b000, 1, 0, 99);
        programWords[4][5] = encodeS(1, 5, 0);
        programWords[4][6] = encodeI(opcodeLoad, 3'b010, 1, 5, 0);
        programWords[4][7] = encodeS(1, 5, 0);
        programWords[4][8] = encodeJ(0, 0);
        expectedCounts[4] = 4;
        expectedLeds[4] = '0;
        expectedLeds[4][2] = 8'd99;
    endtask

    initial begin
        buildPrograms();
        for (int test = 0; test < 5; test++) begin
            @(posedge Clock);
            reset <= 1'b1;
            for (int index = 0; index < 12; index++) begin
                @(posedge Clock);
                loadEnable <= 1'b1;
                loadAddress <= 8'(index);
                loadData <= programWords[test][index];
            end
            @(posedge Clock);
            loadEnable <= 1'b0;
            repeat (4) @(posedge Clock);
            reset <= 1'b0;
            ledChecker.checkTest(testNames[test], expectedCounts[test], expectedLeds[test]);
        end
        $display("tests passed %0d, failed %0d, check errors %0d, assertion failures %0d",
                 ledChecker.passedTests, ledChecker.failedTests, ledChecker.errorCount,
                 uut.busChecks.failureCount);
        if (ledChecker.errorCount == 0 && uut.busChecks.failureCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
source/cpuPackage.sv
source/memoryBus.sv
source/controlUnit.sv
source/registerFile.sv
source/arithmeticUnit.sv
source/programMemory.sv
source/dataMemory.sv
source/peripheralDecoder.sv
source/processorTop.sv
bench/processorAssertions.sv
bench/processorChecker.sv
bench/processorBench.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass message in the output
verilator --binary --timing --assert --top-module processorBench -f sources.f \
    -o processorSim || exit 1
output=$(./obj_dir/processorSim +verilator+error+limit+100)
echo "$output"
echo "$output" | grep -q "Verification passed" && exit 0 || exit 1
